// ==== axi/axi_read_channel.sv ====
`timescale 1ns/1ns

module axi_read_channel (
    input  logic                    clk,
    input  logic                    rst,

    // request side, driven by the router.
    input  logic                    new_request,
    input  logic                    uncached,
    input  core_config::addr_t      addr,
    input  core_config::axi_size_t  size,
    output logic                    ready_out,
    output logic                    done,
    output logic                    err,
    output core_config::axi_data_t  data_out,

    // read address channel.
    input  logic                    arready,
    output logic                    arvalid,
    output core_config::axi_id_t    arid,
    output core_config::axi_len_t   arlen,
    output core_config::axi_burst_t arburst,
    output core_config::axi_size_t  arsize,
    output core_config::addr_t      araddr,
    output core_config::axi_cache_t arcache,

    // read data channel.
    input  logic                    rvalid,
    input  core_config::axi_id_t    rid,
    input  core_config::axi_data_t  rdata,
    input  core_config::axi_resp_t  rresp,
    input  logic                    rlast,
    output logic                    rready
);

    typedef enum logic [1:0] {
        READ_IDLE,
        READ_ADDRESS,
        READ_DATA
    } read_state_t;

    read_state_t state;
    logic r_match;
    logic r_done;

    // rready is tied high, so a valid last beat with our ID ends the read.
    assign r_match = rvalid && rlast && (rid == core_config::READ_ID);
    assign r_done  = (state == READ_DATA) && r_match;

    assign arid    = core_config::READ_ID;
    assign arlen   = '0;
    assign arburst = core_config::AXI_BURST_INCR;
    assign rready  = 1'b1;

    assign arvalid   = (state == READ_ADDRESS);
    assign ready_out = (state == READ_IDLE);

    always_ff @(posedge clk) begin
        if (new_request) begin
            araddr  <= addr;
            arsize  <= size;
            arcache <= uncached ? '0 : '1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= READ_IDLE;
        end else begin
            case (state)
                READ_IDLE: begin
                    if (new_request) begin
                        state <= READ_ADDRESS;
                    end
                end
                READ_ADDRESS: begin
                    if (arready) begin
                        state <= READ_DATA;
                    end
                end
                READ_DATA: begin
                    if (r_match) begin
                        state <= READ_IDLE;
                    end
                end
                default: state <= READ_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (r_done) begin
            data_out <= rdata;
        end
    end

    // completion pulse lines up with ready_out returning high.
    always_ff @(posedge clk) begin
        if (rst) begin
            done <= 1'b0;
            err  <= 1'b0;
        end else begin
            done <= r_done;
            err  <= r_done && (rresp != core_config::AXI_RESP_OKAY);
        end
    end

    no_response_when_idle: assert property (
        @(posedge clk) disable iff (rst) (state == READ_IDLE) |-> !r_match
    ) else $error("read response arrived with no read outstanding");

endmodule

// ==== axi/axi_write_channel.sv ====
`timescale 1ns/1ns

module axi_write_channel (
    input  logic                    clk,
    input  logic                    rst,

    // request side, driven by the router.
    input  logic                    new_request,
    input  logic                    uncached,
    input  core_config::addr_t      addr,
    input  core_config::axi_size_t  size,
    input  core_config::axi_data_t  data_in,
    input  core_config::axi_strb_t  wstrb_in,
    output logic                    ready_out,
    output logic                    done,
    output logic                    err,

    // write address channel.
    input  logic                    awready,
    output logic                    awvalid,
    output core_config::axi_id_t    awid,
    output core_config::axi_len_t   awlen,
    output core_config::axi_burst_t awburst,
    output core_config::axi_size_t  awsize,
    output core_config::addr_t      awaddr,
    output core_config::axi_cache_t awcache,

    // write data channel.
    input  logic                    wready,
    output logic                    wvalid,
    output logic                    wlast,
    output core_config::axi_data_t  wdata,
    output core_config::axi_strb_t  wstrb,
    output core_config::axi_id_t    wid,

    // write response channel.
    input  logic                    bvalid,
    input  core_config::axi_id_t    bid,
    input  core_config::axi_resp_t  bresp,
    output logic                    bready
);

    logic b_match;

    // bready is tied high, so a valid beat with our ID is a completed response.
    assign b_match = bvalid && (bid == core_config::WRITE_ID);

    assign awid    = core_config::WRITE_ID;
    assign wid     = core_config::WRITE_ID;
    assign awlen   = '0;
    assign awburst = core_config::AXI_BURST_INCR;
    assign bready  = 1'b1;

    // single beat, so every data beat is also the last one.
    assign wlast = wvalid;

    always_ff @(posedge clk) begin
        if (new_request) begin
            awaddr  <= addr;
            awsize  <= size;
            wdata   <= data_in;
            wstrb   <= wstrb_in;
            awcache <= uncached ? '0 : '1;
        end
    end

    // a new request wins over a stale ready, so the valids rise right away.
    always_ff @(posedge clk) begin
        if (rst) begin
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
        end else begin
            if (new_request) begin
                awvalid <= 1'b1;
            end else if (awready) begin
                awvalid <= 1'b0;
            end
            if (new_request) begin
                wvalid <= 1'b1;
            end else if (wready) begin
                wvalid <= 1'b0;
            end
        end
    end

    // the channel is busy from the request until its response has been seen.
    always_ff @(posedge clk) begin
        if (rst) begin
            ready_out <= 1'b1;
            done      <= 1'b0;
            err       <= 1'b0;
        end else begin
            if (new_request) begin
                ready_out <= 1'b0;
            end else if (b_match) begin
                ready_out <= 1'b1;
            end
            done <= b_match;
            err  <= b_match && (bresp != core_config::AXI_RESP_OKAY);
        end
    end

    request_while_busy: assert property (
        @(posedge clk) disable iff (rst) new_request |-> ready_out
    ) else $error("write request issued while the write channel is busy");

    awvalid_held: assert property (
        @(posedge clk) disable iff (rst) awvalid && !awready |=> awvalid
    ) else $error("awvalid dropped before awready");

endmodule

// ==== common/core_config.sv ====
package core_config;

    // bus widths shared by the core port and the AXI port.
    localparam int ADDR_WIDTH = 32;
    localparam int AXI_DATA_WIDTH = 32;
    localparam int AXI_STRB_WIDTH = AXI_DATA_WIDTH / 8;

    // lowest address bit above the byte offset within one data word.
    localparam int WORD_LSB = $clog2(AXI_STRB_WIDTH);

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [AXI_DATA_WIDTH-1:0] axi_data_t;
    typedef logic [AXI_STRB_WIDTH-1:0] axi_strb_t;
    typedef logic [7:0] axi_id_t;
    typedef logic [7:0] axi_len_t;
    typedef logic [1:0] axi_burst_t;
    typedef logic [2:0] axi_size_t;
    typedef logic [1:0] axi_resp_t;

    // all zeros for uncached accesses, all ones for cacheable ones.
    typedef logic [3:0] axi_cache_t;

    // each channel has a fixed ID so responses can be matched to it.
    localparam axi_id_t WRITE_ID = 8'd1;
    localparam axi_id_t READ_ID = 8'd2;

    localparam axi_burst_t AXI_BURST_INCR = 2'b01;
    localparam axi_resp_t AXI_RESP_OKAY = 2'b00;

endpackage

// ==== hw/axi_master_bridge.sv ====
`timescale 1ns/1ns

module axi_master_bridge (
    input  logic                    clk,
    input  logic                    rst,

    // core port.
    input  logic                    req,
    input  logic                    req_write,
    input  logic                    req_uncached,
    input  core_config::addr_t      req_addr,
    input  core_config::axi_size_t  req_size,
    input  core_config::axi_data_t  req_wdata,
    input  core_config::axi_strb_t  req_wstrb,
    output logic                    req_ready,
    output logic                    write_done,
    output logic                    write_err,
    output logic                    read_valid,
    output core_config::axi_data_t  read_data,
    output logic                    read_err,

    // AXI write address channel.
    input  logic                    awready,
    output logic                    awvalid,
    output core_config::axi_id_t    awid,
    output core_config::axi_len_t   awlen,
    output core_config::axi_burst_t awburst,
    output core_config::axi_size_t  awsize,
    output core_config::addr_t      awaddr,
    output core_config::axi_cache_t awcache,

    // AXI write data channel.
    input  logic                    wready,
    output logic                    wvalid,
    output logic                    wlast,
    output core_config::axi_data_t  wdata,
    output core_config::axi_strb_t  wstrb,
    output core_config::axi_id_t    wid,

    // AXI write response channel.
    input  logic                    bvalid,
    input  core_config::axi_id_t    bid,
    input  core_config::axi_resp_t  bresp,
    output logic                    bready,

    // AXI read address channel.
    input  logic                    arready,
    output logic                    arvalid,
    output core_config::axi_id_t    arid,
    output core_config::axi_len_t   arlen,
    output core_config::axi_burst_t arburst,
    output core_config::axi_size_t  arsize,
    output core_config::addr_t      araddr,
    output core_config::axi_cache_t arcache,

    // AXI read data channel.
    input  logic                    rvalid,
    input  core_config::axi_id_t    rid,
    input  core_config::axi_data_t  rdata,
    input  core_config::axi_resp_t  rresp,
    input  logic                    rlast,
    output logic                    rready
);

    logic write_request;
    logic read_request;
    logic write_ready;
    logic read_ready;

    axi_request_router axi_request_router_inst (
        .*
    );

    // the AXI ports share their names with the channel ports.
    axi_write_channel axi_write_channel_inst (
        .new_request (write_request),
        .uncached    (req_uncached),
        .addr        (req_addr),
        .size        (req_size),
        .data_in     (req_wdata),
        .wstrb_in    (req_wstrb),
        .ready_out   (write_ready),
        .done        (write_done),
        .err         (write_err),
        .*
    );

    axi_read_channel axi_read_channel_inst (
        .new_request (read_request),
        .uncached    (req_uncached),
        .addr        (req_addr),
        .size        (req_size),
        .ready_out   (read_ready),
        .done        (read_valid),
        .err         (read_err),
        .data_out    (read_data),
        .*
    );

endmodule

// ==== hw/axi_request_router.sv ====
`timescale 1ns/1ns

module axi_request_router (
    input  logic               clk,
    input  logic               rst,

    // core request fields used for steering.
    input  logic               req,
    input  logic               req_write,
    input  core_config::addr_t req_addr,
    output logic               req_ready,

    // channel handshake.
    output logic               write_request,
    output logic               read_request,
    input  logic               write_ready,
    input  logic               read_ready
);

    logic [core_config::ADDR_WIDTH-1:core_config::WORD_LSB] write_word;
    logic same_word;
    logic read_hold;

    // word address of the most recent write; only meaningful while it is in flight.
    always_ff @(posedge clk) begin
        if (write_request) begin
            write_word <= req_addr[core_config::ADDR_WIDTH-1:core_config::WORD_LSB];
        end
    end

    assign same_word = (req_addr[core_config::ADDR_WIDTH-1:core_config::WORD_LSB] == write_word);

    // write_ready is low for exactly as long as the write is outstanding.
    assign read_hold = !write_ready && same_word;

    // req_ready depends only on the request fields and channel state.
    always_comb begin
        if (req_write) begin
            req_ready = write_ready;
        end else begin
            req_ready = read_ready && !read_hold;
        end
    end

    assign write_request = req && req_ready && req_write;
    assign read_request  = req && req_ready && !req_write;

    one_channel_per_cycle: assert property (
        @(posedge clk) disable iff (rst) !(write_request && read_request)
    ) else $error("request steered to both channels at once");

    // the write channel must go busy right after accepting, or the hold would be skipped.
    write_goes_busy: assert property (
        @(posedge clk) disable iff (rst) write_request |=> !write_ready
    ) else $error("write channel still ready after accepting a request");

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and searches the log for the result.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module axi_master_bridge_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/Vaxi_master_bridge_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Test passed$" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

// ==== src.f ====
common/core_config.sv
axi/axi_write_channel.sv
axi/axi_read_channel.sv
hw/axi_request_router.sv
hw/axi_master_bridge.sv
testbench/axi_slave_model.sv
testbench/axi_master_bridge_tb.sv

// ==== testbench/axi_master_bridge_tb.sv ====
`timescale 1ns/1ns

module axi_master_bridge_tb;

    localparam int WAIT_LIMIT = 400;
    localparam int PAIR_COUNT = 40;
    localparam int TRAFFIC_COUNT = 300;

    logic clk;
    logic rst;
    logic req;
    logic req_write;
    logic req_uncached;
    core_config::addr_t req_addr;
    core_config::axi_size_t req_size;
    core_config::axi_data_t req_wdata;
    core_config::axi_strb_t req_wstrb;
    logic req_ready;
    logic write_done;
    logic write_err;
    logic read_valid;
    core_config::axi_data_t read_data;
    logic read_err;

    logic awready;
    logic awvalid;
    core_config::axi_id_t awid;
    core_config::axi_len_t awlen;
    core_config::axi_burst_t awburst;
    core_config::axi_size_t awsize;
    core_config::addr_t awaddr;
    core_config::axi_cache_t awcache;
    logic wready;
    logic wvalid;
    logic wlast;
    core_config::axi_data_t wdata;
    core_config::axi_strb_t wstrb;
    core_config::axi_id_t wid;
    logic bvalid;
    core_config::axi_id_t bid;
    core_config::axi_resp_t bresp;
    logic bready;
    logic arready;
    logic arvalid;
    core_config::axi_id_t arid;
    core_config::axi_len_t arlen;
    core_config::axi_burst_t arburst;
    core_config::axi_size_t arsize;
    core_config::addr_t araddr;
    core_config::axi_cache_t arcache;
    logic rvalid;
    core_config::axi_id_t rid;
    core_config::axi_data_t rdata;
    core_config::axi_resp_t rresp;
    logic rlast;
    logic rready;

    logic [31:0] lfsr_state;
    core_config::axi_data_t model_mem [0:15];
    logic write_err_q [$];
    core_config::axi_data_t read_data_q [$];
    logic read_err_q [$];
    logic [3:0] read_word;
    core_config::addr_t write_addr_exp;
    core_config::axi_size_t write_size_exp;
    core_config::axi_cache_t write_cache_exp;
    core_config::addr_t read_addr_exp;
    core_config::axi_size_t read_size_exp;
    core_config::axi_cache_t read_cache_exp;
    int checks;
    int errors;
    int writes_issued;
    int reads_issued;
    int writes_done;
    int reads_done;

    axi_master_bridge axi_master_bridge_inst (.*);

    axi_slave_model axi_slave_model_inst (.*);

    function automatic logic [31:0] take_bits(int count);
        logic [31:0] value;
        int i;
        value = '0;
        for (i = 0; i < count; i++) begin
            value = {value[30:0], lfsr_state[0]};
            lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
        end
        return value;
    endfunction

    // strobe bit n selects byte lane n of the new word.
    function automatic core_config::axi_data_t merge_bytes(core_config::axi_data_t old_word,
                                                           core_config::axi_data_t new_word,
                                                           core_config::axi_strb_t strb);
        core_config::axi_data_t mask;
        mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        return (old_word & ~mask) | (new_word & mask);
    endfunction

    task automatic check_data(string name, core_config::axi_data_t got,
                              core_config::axi_data_t expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("FAIL %0t %s got %h expected %h", $time, name, got, expected);
        end
    endtask

    task automatic check_flag(string name, logic got, logic expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("FAIL %0t %s got %b expected %b", $time, name, got, expected);
        end
    endtask

    task automatic check_count(string name, int got, int expected);
        checks++;
        if (got != expected) begin
            errors++;
            $display("FAIL %0t %s got %0d expected %0d", $time, name, got, expected);
        end
    endtask

    task automatic check_addr(string name, core_config::addr_t got,
                              core_config::addr_t expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("FAIL %0t %s got %h expected %h", $time, name, got, expected);
        end
    endtask

    task automatic check_size(string name, core_config::axi_size_t got,
                              core_config::axi_size_t expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("FAIL %0t %s got %0d expected %0d", $time, name, got, expected);
        end
    endtask

    task automatic check_cache(string name, core_config::axi_cache_t got,
                               core_config::axi_cache_t expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("FAIL %0t %s got %b expected %b", $time, name, got, expected);
        end
    endtask

    task automatic check_len(string name, core_config::axi_len_t got,
                             core_config::axi_len_t expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("FAIL %0t %s got %0d expected %0d", $time, name, got, expected);
        end
    endtask

    task automatic check_burst(string name, core_config::axi_burst_t got,
                               core_config::axi_burst_t expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("FAIL %0t %s got %b expected %b", $time, name, got, expected);
        end
    endtask

    task automatic check_id(string name, core_config::axi_id_t got,
                            core_config::axi_id_t expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("FAIL %0t %s got %0d expected %0d", $time, name, got, expected);
        end
    endtask

    task automatic stop_on_timeout(string what);
        $display("timeout at %0t while waiting for %s", $time, what);
        $display("Test failed");
        $finish;
    endtask

    // returns 1 ns after a falling edge, so queue state is settled when the next call looks at it.
    task automatic issue(logic write, logic [3:0] word, logic high, core_config::axi_strb_t strb,
                         core_config::axi_data_t data);
        int waited;
        waited = 0;
        // the bridge only holds reads behind writes, so a write waits out a read of its word.
        while (write && read_err_q.size() != 0 && read_word == word) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                stop_on_timeout("a read to finish before a write to its word");
            end
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        req_write = write;
        req_uncached = 1'(take_bits(1));
        req_addr = {high, 25'd0, word, 2'b00};
        req_size = 3'd2;
        req_wdata = data;
        req_wstrb = strb;
        req = 1'b1;
        #1;
        waited = 0;
        while (!req_ready) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                stop_on_timeout("req_ready");
            end
            @(negedge clk);
            #1;
        end
        if (write) begin
            if (!high) begin
                model_mem[word] = merge_bytes(model_mem[word], data, strb);
            end
            write_err_q.push_back(high);
            write_addr_exp = req_addr;
            write_size_exp = req_size;
            write_cache_exp = req_uncached ? 4'b0000 : 4'b1111;
            writes_issued++;
        end else begin
            read_data_q.push_back(model_mem[word]);
            read_err_q.push_back(high);
            read_word = word;
            read_addr_exp = req_addr;
            read_size_exp = req_size;
            read_cache_exp = req_uncached ? 4'b0000 : 4'b1111;
            reads_issued++;
        end
        @(negedge clk);
        req = 1'b0;
        #1;
    endtask

    task automatic random_request();
        logic write;
        logic high;
        logic [3:0] word;
        core_config::axi_strb_t strb;
        core_config::axi_data_t data;
        write = 1'(take_bits(1));
        high = (3'(take_bits(3)) == 3'd0);
        word = 4'(take_bits(4));
        strb = 4'(take_bits(4));
        data = take_bits(32);
        issue(write, word, high, strb, data);
    endtask

    task automatic wait_for_drain();
        int waited;
        waited = 0;
        while (write_err_q.size() != 0 || read_err_q.size() != 0) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                stop_on_timeout("outstanding completions");
            end
            @(negedge clk);
            #1;
        end
    endtask

    task automatic end_test(string name, int errors_before, int checks_before);
        $display("test %s done: %0d checks, %0d errors", name, checks - checks_before,
                 errors - errors_before);
    endtask

    always @(negedge clk) begin : completion_monitor
        logic expected_err;
        core_config::axi_data_t expected_data;
        if (!rst && write_done) begin
            writes_done++;
            if (write_err_q.size() == 0) begin
                errors++;
                $display("write completion at %0t with no write outstanding", $time);
            end else begin
                check_flag("write_err", write_err, write_err_q.pop_front());
            end
        end
        if (!rst && read_valid) begin
            reads_done++;
            if (read_err_q.size() == 0) begin
                errors++;
                $display("read completion at %0t with no read outstanding", $time);
            end else begin
                expected_err = read_err_q.pop_front();
                expected_data = read_data_q.pop_front();
                check_flag("read_err", read_err, expected_err);
                if (!expected_err) begin
                    check_data("read_data", read_data, expected_data);
                end
            end
        end
    end

    // address and data beats carry the request's fields and the single-beat INCR settings.
    always @(negedge clk) begin : beat_monitor
        if (!rst && awvalid) begin
            check_addr("awaddr", awaddr, write_addr_exp);
            check_size("awsize", awsize, write_size_exp);
            check_cache("awcache", awcache, write_cache_exp);
            check_len("awlen", awlen, 8'd0);
            check_burst("awburst", awburst, 2'b01);
            check_id("awid", awid, 8'd1);
        end
        if (!rst && wvalid) begin
            check_flag("wlast", wlast, 1'b1);
            check_id("wid", wid, 8'd1);
        end
        if (!rst && arvalid) begin
            check_addr("araddr", araddr, read_addr_exp);
            check_size("arsize", arsize, read_size_exp);
            check_cache("arcache", arcache, read_cache_exp);
            check_len("arlen", arlen, 8'd0);
            check_burst("arburst", arburst, 2'b01);
            check_id("arid", arid, 8'd2);
        end
    end

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin : stimulus
        int err_base;
        int chk_base;
        int n;
        logic [3:0] pair_word;
        core_config::axi_strb_t pair_strb;
        core_config::axi_data_t pair_data;
        rst = 1'b1;
        req = 1'b0;
        req_write = 1'b0;
        req_uncached = 1'b0;
        req_addr = '0;
        req_size = 3'd2;
        req_wdata = '0;
        req_wstrb = '0;
        lfsr_state = 32'd58;
        read_word = '0;
        checks = 0;
        errors = 0;
        writes_issued = 0;
        reads_issued = 0;
        writes_done = 0;
        reads_done = 0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        #1;

        err_base = errors;
        chk_base = checks;
        for (n = 0; n < 4; n++) begin
            check_flag("req_ready", req_ready, 1'b1);
            check_flag("write_done", write_done, 1'b0);
            check_flag("read_valid", read_valid, 1'b0);
            @(negedge clk);
            #1;
        end
        end_test("reset_idle", err_base, chk_base);

        err_base = errors;
        chk_base = checks;
        for (n = 0; n < 16; n++) begin
            issue(1'b1, 4'(n), 1'b0, 4'hf, take_bits(32));
        end
        wait_for_drain();
        end_test("fill_words", err_base, chk_base);

        // each read follows its write at once, so it has to pass through the hold.
        err_base = errors;
        chk_base = checks;
        for (n = 0; n < PAIR_COUNT; n++) begin
            pair_word = 4'(take_bits(4));
            pair_strb = 4'(take_bits(4));
            pair_data = take_bits(32);
            issue(1'b1, pair_word, 1'b0, pair_strb, pair_data);
            issue(1'b0, pair_word, 1'b0, '0, '0);
        end
        wait_for_drain();
        end_test("write_then_read", err_base, chk_base);

        err_base = errors;
        chk_base = checks;
        for (n = 0; n < TRAFFIC_COUNT; n++) begin
            random_request();
        end
        wait_for_drain();
        end_test("random_traffic", err_base, chk_base);

        err_base = errors;
        chk_base = checks;
        check_count("write completions", writes_done, writes_issued);
        check_count("read completions", reads_done, reads_issued);
        end_test("completion_count", err_base, chk_base);

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== testbench/axi_slave_model.sv ====
`timescale 1ns/1ns

module axi_slave_model (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   awvalid,
    input  core_config::axi_id_t   awid,
    input  core_config::addr_t     awaddr,
    output logic                   awready,
    input  logic                   wvalid,
    input  core_config::axi_data_t wdata,
    input  core_config::axi_strb_t wstrb,
    output logic                   wready,
    input  logic                   bready,
    output logic                   bvalid,
    output core_config::axi_id_t   bid,
    output core_config::axi_resp_t bresp,
    input  logic                   arvalid,
    input  core_config::axi_id_t   arid,
    input  core_config::addr_t     araddr,
    output logic                   arready,
    input  logic                   rready,
    output logic                   rvalid,
    output core_config::axi_id_t   rid,
    output core_config::axi_data_t rdata,
    output core_config::axi_resp_t rresp,
    output logic                   rlast
);

    localparam core_config::axi_resp_t RESP_SLVERR = 2'b10;

    logic [7:0] mem [0:63];
    logic [31:0] stall_state;
    logic aw_have;
    logic w_have;
    logic b_wait;
    logic r_wait;
    logic [1:0] b_delay;
    logic [1:0] r_delay;
    logic [2:0] lane;
    logic [6:0] fill_index;
    core_config::addr_t aw_addr;
    core_config::axi_data_t w_data;
    core_config::axi_strb_t w_strb;

    // galois LFSR, one step for every bit handed out.
    function automatic logic [31:0] stall_bits(int count);
        logic [31:0] value;
        int i;
        value = '0;
        for (i = 0; i < count; i++) begin
            value = {value[30:0], stall_state[0]};
            stall_state = (stall_state >> 1) ^ (stall_state[0] ? 32'h8020_0003 : 32'h0);
        end
        return value;
    endfunction

    // every output changes on the falling edge, half a cycle before the bridge samples it.
    initial begin
        awready = 1'b0;
        wready = 1'b0;
        arready = 1'b0;
        bvalid = 1'b0;
        bid = '0;
        bresp = core_config::AXI_RESP_OKAY;
        rvalid = 1'b0;
        rid = '0;
        rdata = '0;
        rresp = core_config::AXI_RESP_OKAY;
        rlast = 1'b0;
        stall_state = 32'd58;
        for (fill_index = 7'd0; fill_index < 7'd64; fill_index++) begin
            mem[fill_index[5:0]] = {2'b10, fill_index[5:0]};
        end
        forever begin
            @(negedge clk);
            if (rst) begin
                awready = 1'b0;
                wready = 1'b0;
                arready = 1'b0;
                bvalid = 1'b0;
                rvalid = 1'b0;
                rlast = 1'b0;
                aw_have = 1'b0;
                w_have = 1'b0;
                b_wait = 1'b0;
                r_wait = 1'b0;
            end else begin
                if (bvalid && bready) begin
                    bvalid = 1'b0;
                    aw_have = 1'b0;
                    w_have = 1'b0;
                end else if (b_wait) begin
                    if (b_delay == 2'd0) begin
                        bvalid = 1'b1;
                        b_wait = 1'b0;
                    end else begin
                        b_delay = b_delay - 2'd1;
                    end
                end else if (aw_have && w_have && !bvalid) begin
                    // error addresses leave the memory untouched.
                    if (!aw_addr[31]) begin
                        for (lane = 3'd0; lane < 3'd4; lane++) begin
                            if (w_strb[lane[1:0]]) begin
                                mem[{aw_addr[5:2], lane[1:0]}] = w_data[{lane[1:0], 3'b000} +: 8];
                            end
                        end
                    end
                    bresp = aw_addr[31] ? RESP_SLVERR : core_config::AXI_RESP_OKAY;
                    b_delay = 2'(stall_bits(2));
                    b_wait = 1'b1;
                end
                awready = !aw_have && 1'(stall_bits(1));
                if (awvalid && awready) begin
                    aw_have = 1'b1;
                    aw_addr = awaddr;
                    bid = awid;
                end
                wready = !w_have && 1'(stall_bits(1));
                if (wvalid && wready) begin
                    w_have = 1'b1;
                    w_data = wdata;
                    w_strb = wstrb;
                end
                if (rvalid && rready) begin
                    rvalid = 1'b0;
                    rlast = 1'b0;
                end else if (r_wait) begin
                    if (r_delay == 2'd0) begin
                        rvalid = 1'b1;
                        rlast = 1'b1;
                        r_wait = 1'b0;
                    end else begin
                        r_delay = r_delay - 2'd1;
                    end
                end
                arready = !r_wait && !rvalid && 1'(stall_bits(1));
                if (arvalid && arready) begin
                    rid = arid;
                    rresp = araddr[31] ? RESP_SLVERR : core_config::AXI_RESP_OKAY;
                    rdata = araddr[31] ? '0 : {mem[{araddr[5:2], 2'd3}], mem[{araddr[5:2], 2'd2}],
                                               mem[{araddr[5:2], 2'd1}], mem[{araddr[5:2], 2'd0}]};
                    r_delay = 2'(stall_bits(2));
                    r_wait = 1'b1;
                end
            end
        end
    end

endmodule
